// File: all.f
lcdPkg.sv
lcdNibbleWriter.sv
lcdInitSequencer.sv
lcdCharWriter.sv
lcdBusArbiter.sv
lcdController.sv
lcdControllerTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing
TOP = lcdControllerTb
FILELIST = all.f
BUILDDIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP)

clean:
	rm -rf $(BUILDDIR)

// File: lcdControllerTb.sv
`default_nettype none

module lcdControllerTb;

        import lcdPkg::*;

        localparam int StimCount = 8;
        localparam logic [31:0] Seed = 32'h55326835;

        logic Clock;
        logic rst;
        logic write;
        lcdByte_t data;
        logic ready;
        logic lcdEnable;
        logic lcdRegisterSelect;
        logic lcdReadWrite;
        logic lcdFlashDisable;
        logic [NibbleWidth-1:0] lcdData;

        // stimulus table, one byte and the idle gap before it per entry
        lcdByte_t stimByte [StimCount];
        int stimGap [StimCount];

        logic [NibbleWidth-1:0] initNibbleTable [InitStepCount];
        int initWaitTable [InitStepCount];

        // what the bus should show, in pulse order
        logic [NibbleWidth-1:0] expNibbleQ [$];
        logic expRsQ [$];
        int expWaitQ [$];
        lcdByte_t expByteQ [$];

        int cycle;
        int timeoutLimit;
        int resetCycle;
        int riseCycle;
        int fallCycle;
        int pulseCount;
        int lastWait;
        logic prevEnable;
        logic readySeen;
        logic haveHigh;
        logic [NibbleWidth-1:0] highNibble;
        logic [NibbleWidth-1:0] expNibble;
        logic expRs;
        lcdByte_t rebuilt;
        lcdByte_t expByte;
        logic [31:0] randomWord;

        lcdController dut0 (
                .Clock(Clock),
                .rst(rst),
                .write(write),
                .data(data),
                .ready(ready),
                .lcdEnable(lcdEnable),
                .lcdRegisterSelect(lcdRegisterSelect),
                .lcdReadWrite(lcdReadWrite),
                .lcdFlashDisable(lcdFlashDisable),
                .lcdData(lcdData)
        );

        always #10 Clock = ~Clock;

        task automatic abortRun(input string why);
                $display("%s", why);
                $display("Test failed");
                $fatal(1);
        endtask

        task automatic checkNibble(input string name, input logic [NibbleWidth-1:0] actual,
                        input logic [NibbleWidth-1:0] expected);
                if (actual !== expected)
                        abortRun($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                $time, name, actual, expected));
        endtask

        task automatic checkBit(input string name, input logic actual, input logic expected);
                if (actual !== expected)
                        abortRun($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                                $time, name, actual, expected));
        endtask

        task automatic checkByte(input string name, input lcdByte_t actual,
                        input lcdByte_t expected);
                if (actual.whole !== expected.whole)
                        abortRun($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                $time, name, actual.whole, expected.whole));
        endtask

        // atLeast turns the count into a lower bound
        task automatic checkCycles(input string name, input int actual, input int expected,
                        input logic atLeast);
                if (atLeast ? (actual < expected) : (actual != expected))
                        abortRun($sformatf("CHECK FAILED at %0t: %s is %0d, expected %s%0d",
                                $time, name, actual, atLeast ? "at least " : "", expected));
        endtask

        // strobe write while the DUT is busy, must be dropped
        task automatic strayWrite(input logic [7:0] value);
                checkBit("ready", ready, 1'b0);
                write = 1'b1;
                data.whole = value;
                @(negedge Clock);
                write = 1'b0;
        endtask

        // each host byte goes out high nibble first
        task automatic expectByte(input lcdByte_t value);
                expByteQ.push_back(value);
                expNibbleQ.push_back(value.nibbles.high);
                expRsQ.push_back(1'b1);
                expWaitQ.push_back(int'(WaitNibble));
                expNibbleQ.push_back(value.nibbles.low);
                expRsQ.push_back(1'b1);
                expWaitQ.push_back(int'(WaitCommand));
        endtask

        // bus monitor, sampled at the rising edge
        always @(posedge Clock)
        begin
                cycle = cycle + 1;
                if (cycle > timeoutLimit)
                        abortRun($sformatf("timeout after %0d cycles with %0d enable pulses seen",
                                cycle, pulseCount));
                if (rst)
                        resetCycle = cycle;
                else
                begin
                        checkBit("lcdReadWrite", lcdReadWrite, 1'b0);
                        checkBit("lcdFlashDisable", lcdFlashDisable, 1'b1);
                        if (lcdEnable && !prevEnable)
                        begin
                                if (pulseCount == 0)
                                        checkCycles("power-on wait", cycle - resetCycle,
                                                int'(PowerOnWait), 1'b1);
                                else
                                        checkCycles("enable low time", cycle - fallCycle,
                                                lastWait, 1'b1);
                                if (expNibbleQ.size() == 0)
                                        abortRun("an enable pulse came when no nibble was due");
                                expNibble = expNibbleQ.pop_front();
                                expRs = expRsQ.pop_front();
                                lastWait = expWaitQ.pop_front();
                                checkBit("lcdRegisterSelect", lcdRegisterSelect, expRs);
                                checkNibble("lcdData", lcdData, expNibble);
                                if (lcdRegisterSelect && !haveHigh)
                                begin
                                        highNibble = lcdData;
                                        haveHigh = 1'b1;
                                end
                                else if (lcdRegisterSelect)
                                begin
                                        rebuilt.nibbles.high = highNibble;
                                        rebuilt.nibbles.low = lcdData;
                                        expByte = expByteQ.pop_front();
                                        checkByte("rebuilt byte", rebuilt, expByte);
                                        haveHigh = 1'b0;
                                end
                                riseCycle = cycle;
                                pulseCount = pulseCount + 1;
                        end
                        if (!lcdEnable && prevEnable)
                        begin
                                checkCycles("enable pulse width", cycle - riseCycle,
                                        int'(EnableCycles), 1'b0);
                                fallCycle = cycle;
                        end
                        if (ready && !readySeen)
                        begin
                                readySeen = 1'b1;
                                checkCycles("pulses before ready", pulseCount, InitStepCount, 1'b0);
                                checkCycles("wait before ready", cycle - fallCycle,
                                        int'(WaitCommand), 1'b1);
                        end
                end
                prevEnable = lcdEnable;
        end

        initial
        begin
                int maxGap;
                int initSum;
                Clock = 1'b0;
                rst = 1'b1;
                write = 1'b0;
                data = '0;
                cycle = 0;
                pulseCount = 0;
                resetCycle = 0;
                riseCycle = 0;
                fallCycle = 0;
                lastWait = 0;
                prevEnable = 1'b0;
                readySeen = 1'b0;
                haveHigh = 1'b0;
                randomWord = $urandom(Seed);

                initNibbleTable = '{4'h3, 4'h3, 4'h3, 4'h2, 4'h2, 4'h8, 4'h0,
                        4'h6, 4'h0, 4'hC, 4'h0, 4'h1, 4'h8, 4'h0};
                initWaitTable = '{int'(WaitInitFirst), int'(WaitInitSecond), int'(WaitCommand),
                        int'(WaitCommand), int'(WaitNibble), int'(WaitCommand), int'(WaitNibble),
                        int'(WaitCommand), int'(WaitNibble), int'(WaitCommand), int'(WaitNibble),
                        int'(WaitClear), int'(WaitNibble), int'(WaitCommand)};

                stimByte[0].whole = 8'h48;
                stimByte[1].whole = 8'h69;
                randomWord = $urandom();
                stimByte[2].whole = randomWord[7:0];
                stimByte[3].whole = 8'h00;
                stimByte[4].whole = 8'hFF;
                randomWord = $urandom();
                stimByte[5].whole = randomWord[7:0];
                stimByte[6].whole = 8'hA5;
                stimByte[7].whole = 8'h3C;
                stimGap = '{0, 3, 10, 0, 50, 1, 7, 20};

                maxGap = 0;
                initSum = 0;
                for (int i = 0; i < StimCount; i++)
                        if (stimGap[i] > maxGap)
                                maxGap = stimGap[i];
                for (int i = 0; i < InitStepCount; i++)
                begin
                        initSum = initSum + initWaitTable[i];
                        expNibbleQ.push_back(initNibbleTable[i]);
                        expRsQ.push_back(1'b0);
                        expWaitQ.push_back(initWaitTable[i]);
                end
                // margin covers reset and a few handshake cycles per nibble
                timeoutLimit = int'(PowerOnWait) + initSum + StimCount * (2 * int'(EnableCycles)
                        + int'(WaitNibble) + int'(WaitCommand) + maxGap) + 2000;

                repeat (16) @(negedge Clock);
                checkBit("ready", ready, 1'b0);
                checkBit("lcdEnable", lcdEnable, 1'b0);
                checkBit("lcdRegisterSelect", lcdRegisterSelect, 1'b0);
                checkNibble("lcdData", lcdData, 4'h0);
                rst = 1'b0;

                repeat (100) @(negedge Clock);
                strayWrite(8'hEE);              // still in the power-on wait
                while (pulseCount < 3)
                        @(negedge Clock);
                strayWrite(8'h5A);              // during the init nibbles

                for (int i = 0; i < StimCount; i++)
                begin
                        while (!ready)
                                @(negedge Clock);
                        repeat (stimGap[i]) @(negedge Clock);   // host idles while ready
                        expectByte(stimByte[i]);
                        write = 1'b1;
                        data = stimByte[i];
                        @(negedge Clock);
                        write = 1'b0;
                        repeat (20) @(negedge Clock);
                        strayWrite(~stimByte[i].whole);     // lands between the two nibbles
                end
                while (!ready)
                        @(negedge Clock);

                checkCycles("enable pulse count", pulseCount, InitStepCount + 2 * StimCount, 1'b0);
                $display("Test completed successfully");
                $finish;
        end

endmodule

`default_nettype wire

// File: lcdController.sv
`default_nettype none

module lcdController (
        input wire Clock,
        input wire rst,
        input wire write,
        input wire lcdPkg::lcdByte_t data,
        output logic ready,
        output logic lcdEnable,
        output logic lcdRegisterSelect,
        output logic lcdReadWrite,
        output logic lcdFlashDisable,
        output logic [lcdPkg::NibbleWidth-1:0] lcdData
);

        import lcdPkg::*;

        logic initReq;
        logic [NibbleWidth-1:0] initNibble;
        logic initRs;
        logic [DelayWidth-1:0] initWait;
        logic initDone;
        logic initGrantDone;

        logic charReq;
        logic [NibbleWidth-1:0] charNibble;
        logic charRs;
        logic [DelayWidth-1:0] charWait;
        logic charGrantDone;
        logic charGrant;

        logic writerReq;
        logic [NibbleWidth-1:0] writerNibble;
        logic writerRs;
        logic [DelayWidth-1:0] writerWait;
        logic writerDone;

        assign lcdReadWrite = 1'b0;             // write only
        assign lcdFlashDisable = 1'b1;          // keep the flash off the shared data lines

        lcdInitSequencer initSeq0 (
                .Clock(Clock),
                .rst(rst),
                .grantDone(initGrantDone),
                .req(initReq),
                .nibble(initNibble),
                .rs(initRs),
                .waitCycles(initWait),
                .initDone(initDone)
        );

        lcdCharWriter charWriter0 (
                .Clock(Clock),
                .rst(rst),
                .write(write),
                .data(data),
                .charGrant(charGrant),
                .grantDone(charGrantDone),
                .ready(ready),
                .req(charReq),
                .nibble(charNibble),
                .rs(charRs),
                .waitCycles(charWait)
        );

        lcdBusArbiter arbiter0 (
                .Clock(Clock),
                .rst(rst),
                .initReq(initReq),
                .initNibble(initNibble),
                .initRs(initRs),
                .initWait(initWait),
                .initDone(initDone),
                .charReq(charReq),
                .charNibble(charNibble),
                .charRs(charRs),
                .charWait(charWait),
                .writerDone(writerDone),
                .writerReq(writerReq),
                .writerNibble(writerNibble),
                .writerRs(writerRs),
                .writerWait(writerWait),
                .initGrantDone(initGrantDone),
                .charGrantDone(charGrantDone),
                .charGrant(charGrant)
        );

        // sole driver of the LCD bus
        lcdNibbleWriter nibbleWriter0 (
                .Clock(Clock),
                .rst(rst),
                .start(writerReq),
                .nibble(writerNibble),
                .rs(writerRs),
                .waitCycles(writerWait),
                .done(writerDone),
                .lcdEnable(lcdEnable),
                .lcdRegisterSelect(lcdRegisterSelect),
                .lcdData(lcdData)
        );

endmodule

`default_nettype wire

// File: lcdBusArbiter.sv
`default_nettype none

module lcdBusArbiter (
        input wire Clock,
        input wire rst,
        input wire initReq,
        input wire [lcdPkg::NibbleWidth-1:0] initNibble,
        input wire initRs,
        input wire [lcdPkg::DelayWidth-1:0] initWait,
        input wire initDone,
        input wire charReq,
        input wire [lcdPkg::NibbleWidth-1:0] charNibble,
        input wire charRs,
        input wire [lcdPkg::DelayWidth-1:0] charWait,
        input wire writerDone,
        output logic writerReq,
        output logic [lcdPkg::NibbleWidth-1:0] writerNibble,
        output logic writerRs,
        output logic [lcdPkg::DelayWidth-1:0] writerWait,
        output logic initGrantDone,
        output logic charGrantDone,
        output logic charGrant
);

        logic charOwner;                        // 0 while the init sequence runs

        always_ff @(posedge Clock)
        begin
                if (rst)
                        charOwner <= 1'b0;
                else if (initDone)
                        charOwner <= 1'b1;      // hand over once, never back
        end

        assign charGrant = charOwner;

        assign writerReq = charOwner ? charReq : initReq;
        assign writerNibble = charOwner ? charNibble : initNibble;
        assign writerRs = charOwner ? charRs : initRs;
        assign writerWait = charOwner ? charWait : initWait;

        // done only goes back to the owner
        assign initGrantDone = writerDone && !charOwner;
        assign charGrantDone = writerDone && charOwner;

endmodule

`default_nettype wire

// File: lcdCharWriter.sv
`default_nettype none

module lcdCharWriter (
        input wire Clock,
        input wire rst,
        input wire write,
        input wire lcdPkg::lcdByte_t data,
        input wire charGrant,
        input wire grantDone,
        output logic ready,
        output logic req,
        output logic [lcdPkg::NibbleWidth-1:0] nibble,
        output logic rs,
        output logic [lcdPkg::DelayWidth-1:0] waitCycles
);

        import lcdPkg::*;

        logic [1:0] state;
        lcdByte_t byteReg;

        assign ready = (state == CharIdle) && charGrant;
        assign rs = 1'b1;                       // host bytes are always data

        // short gap inside the byte, full command wait after it
        assign nibble = (state == CharLow) ? byteReg.nibbles.low : byteReg.nibbles.high;
        assign waitCycles = (state == CharLow) ? WaitCommand : WaitNibble;

        always_ff @(posedge Clock)
        begin
                if (write && ready)
                        byteReg <= data;
        end

        always_ff @(posedge Clock)
        begin
                if (rst)
                begin
                        state <= CharIdle;
                        req <= 1'b0;
                end
                else
                begin
                        req <= 1'b0;
                        case (state)
                                CharIdle:
                                        if (write && ready)     // ignored while not ready
                                        begin
                                                state <= CharHigh;
                                                req <= 1'b1;
                                        end
                                CharHigh:
                                        if (grantDone)
                                        begin
                                                state <= CharLow;
                                                req <= 1'b1;
                                        end
                                CharLow:
                                        if (grantDone)
                                                state <= CharIdle;
                                default:
                                        state <= CharIdle;
                        endcase
                end
        end

endmodule

`default_nettype wire

// File: lcdInitSequencer.sv
`default_nettype none

module lcdInitSequencer (
        input wire Clock,
        input wire rst,
        input wire grantDone,
        output logic req,
        output logic [lcdPkg::NibbleWidth-1:0] nibble,
        output logic rs,
        output logic [lcdPkg::DelayWidth-1:0] waitCycles,
        output logic initDone
);

        import lcdPkg::*;

        logic [DelayWidth-1:0] powerCount;
        logic [$clog2(InitStepCount)-1:0] stepIndex;
        logic busy;                             // a nibble is out, waiting for done

        assign rs = 1'b0;                       // init only sends commands

        // nibble of each step, 8-bit commands split high then low
        always_comb
        begin
                case (stepIndex)
                        4'd0: nibble = 4'h3;
                        4'd1: nibble = 4'h3;
                        4'd2: nibble = 4'h3;
                        4'd3: nibble = 4'h2;
                        4'd4: nibble = 4'h2;    // function set 0x28
                        4'd5: nibble = 4'h8;
                        4'd6: nibble = 4'h0;    // entry mode 0x06
                        4'd7: nibble = 4'h6;
                        4'd8: nibble = 4'h0;    // display on 0x0C
                        4'd9: nibble = 4'hC;
                        4'd10: nibble = 4'h0;   // clear 0x01
                        4'd11: nibble = 4'h1;
                        4'd12: nibble = 4'h8;   // DD address 0x80
                        default: nibble = 4'h0;
                endcase
        end

        // wait after each step
        always_comb
        begin
                case (stepIndex)
                        4'd0: waitCycles = WaitInitFirst;
                        4'd1: waitCycles = WaitInitSecond;
                        4'd4: waitCycles = WaitNibble;
                        4'd6: waitCycles = WaitNibble;
                        4'd8: waitCycles = WaitNibble;
                        4'd10: waitCycles = WaitNibble;
                        4'd11: waitCycles = WaitClear;  // clear is slow
                        4'd12: waitCycles = WaitNibble;
                        default: waitCycles = WaitCommand;
                endcase
        end

        always_ff @(posedge Clock)
        begin
                if (rst)
                begin
                        powerCount <= '0;
                        stepIndex <= '0;
                        busy <= 1'b0;
                        req <= 1'b0;
                        initDone <= 1'b0;
                end
                else
                begin
                        req <= 1'b0;
                        if (!initDone)
                        begin
                                if (powerCount != PowerOnWait)
                                        powerCount <= powerCount + 1'b1;
                                else if (!busy)
                                begin
                                        req <= 1'b1;
                                        busy <= 1'b1;
                                end
                                else if (grantDone)
                                begin
                                        busy <= 1'b0;
                                        if (int'(stepIndex) == InitStepCount - 1)
                                                initDone <= 1'b1;       // stays until reset
                                        else
                                                stepIndex <= stepIndex + 1'b1;
                                end
                        end
                end
        end

endmodule

`default_nettype wire

// File: lcdNibbleWriter.sv
`default_nettype none

module lcdNibbleWriter (
        input wire Clock,
        input wire rst,
        input wire start,
        input wire [lcdPkg::NibbleWidth-1:0] nibble,
        input wire rs,
        input wire [lcdPkg::DelayWidth-1:0] waitCycles,
        output logic done,
        output logic lcdEnable,
        output logic lcdRegisterSelect,
        output logic [lcdPkg::NibbleWidth-1:0] lcdData
);

        import lcdPkg::*;

        logic waiting;                          // enable low, counting the wait
        logic [DelayWidth-1:0] count;
        logic [DelayWidth-1:0] waitLength;
        logic idle;

        assign idle = !lcdEnable && !waiting;

        // wait after the nibble being sent
        always_ff @(posedge Clock)
        begin
                if (start && idle)
                        waitLength <= waitCycles;
        end

        always_ff @(posedge Clock)
        begin
                if (rst)
                begin
                        lcdEnable <= 1'b0;
                        waiting <= 1'b0;
                        done <= 1'b0;
                        count <= '0;
                        lcdRegisterSelect <= 1'b0;
                        lcdData <= '0;
                end
                else
                begin
                        done <= 1'b0;
                        if (start && idle)
                        begin
                                lcdEnable <= 1'b1;
                                count <= EnableCycles - 1'b1;
                                lcdData <= nibble;      // held until the next start
                                lcdRegisterSelect <= rs;
                        end
                        else if (lcdEnable)
                        begin
                                if (count == '0)
                                begin
                                        // pulse over, switch to the wait phase
                                        lcdEnable <= 1'b0;
                                        waiting <= 1'b1;
                                        count <= waitLength - 1'b1;
                                end
                                else
                                        count <= count - 1'b1;
                        end
                        else if (waiting)
                        begin
                                if (count == '0)
                                begin
                                        waiting <= 1'b0;
                                        done <= 1'b1;
                                end
                                else
                                        count <= count - 1'b1;
                        end
                end
        end

endmodule

`default_nettype wire

// File: lcdPkg.sv
`default_nettype none

package lcdPkg;

        localparam int NibbleWidth = 4;
        localparam int DelayWidth = 20;         // big enough for the power-on wait

        // all waits in 50 MHz clock cycles
        localparam logic [DelayWidth-1:0] EnableCycles = 20'd12;
        localparam logic [DelayWidth-1:0] PowerOnWait = 20'd750000;     // 15 ms
        localparam logic [DelayWidth-1:0] WaitInitFirst = 20'd205000;   // 4.1 ms
        localparam logic [DelayWidth-1:0] WaitInitSecond = 20'd5000;    // 100 us
        localparam logic [DelayWidth-1:0] WaitCommand = 20'd2000;       // 40 us
        localparam logic [DelayWidth-1:0] WaitNibble = 20'd50;          // 1 us
        localparam logic [DelayWidth-1:0] WaitClear = 20'd82000;        // 1.64 ms

        localparam int InitStepCount = 14;

        // character writer states
        localparam logic [1:0] CharIdle = 2'd0;
        localparam logic [1:0] CharHigh = 2'd1;
        localparam logic [1:0] CharLow = 2'd2;

        // one LCD byte, either whole or split for the 4-bit bus
        typedef union packed {
                logic [2*NibbleWidth-1:0] whole;
                struct packed {
                        logic [NibbleWidth-1:0] high;   // goes out first
                        logic [NibbleWidth-1:0] low;
                } nibbles;
        } lcdByte_t;

endpackage

`default_nettype wire
